//--- Makefile
# Verilator flow for the L2 tag directory

TOP := tb_l2_tag_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f l2_tag_dir.f
	verilator --lint-only --top-module l2_tag_dir \
		design/l2_tag_pkg.sv design/l2_req_front.sv design/l2_way_bank.sv \
		design/l2_way_resolve.sv design/l2_tag_dir.sv

obj_dir/V$(TOP): l2_tag_dir.f design/*.sv sim/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f l2_tag_dir.f

# The log decides the result, not the simulator exit code
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/l2_req_front.sv
`timescale 1ns/1ps

module l2_req_front (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  l2_tag_pkg::l2_req_t     req,
    input  logic                    touch,
    input  l2_tag_pkg::way_idx_t    touch_way,
    output l2_tag_pkg::l2_stage_t   stage
);

    //////////////////////////////////////////////////
    // PLRU helpers
    //////////////////////////////////////////////////

    // Point every node on the way's path toward that way
    function automatic l2_tag_pkg::plru_tree_t plru_touch(
        input l2_tag_pkg::plru_tree_t tree,
        input l2_tag_pkg::way_idx_t   way
    );
        l2_tag_pkg::plru_tree_t t;
        int                     leaf;
        t    = tree;
        leaf = 3 + int'(way[2:1]);
        t[0] = ~way[2];
        if (!way[2]) begin
            t[1] = ~way[1];
        end else begin
            t[2] = ~way[1];
        end
        t[leaf] = ~way[0];
        return t;
    endfunction

    // Walk away from the recent side at each level
    function automatic l2_tag_pkg::way_idx_t plru_victim(
        input l2_tag_pkg::plru_tree_t tree
    );
        l2_tag_pkg::way_idx_t v;
        int                   leaf;
        v[2] = tree[0];
        v[1] = v[2] ? tree[2] : tree[1];
        leaf = 3 + int'({v[2], v[1]});
        v[0] = tree[leaf];
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    logic                   valid_q;
    logic                   inval_q;
    l2_tag_pkg::set_idx_t   set_q;
    l2_tag_pkg::tag_t       tag_q;

    l2_tag_pkg::plru_tree_t plru_q [l2_tag_pkg::NUM_SETS];
    l2_tag_pkg::way_idx_t   victim;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            inval_q <= req.inval;
            set_q   <= req.addr[l2_tag_pkg::OFFSET_BITS +: l2_tag_pkg::SET_BITS];
            tag_q   <= req.addr[l2_tag_pkg::OFFSET_BITS + l2_tag_pkg::SET_BITS +:
                                l2_tag_pkg::TAG_BITS];
        end
    end

    //////////////////////////////////////////////////
    // Per-set PLRU trees
    //////////////////////////////////////////////////

    // Touch always refers to the set now in stage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < l2_tag_pkg::NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (touch) begin
            plru_q[set_q] <= plru_touch(plru_q[set_q], touch_way);
        end
    end

    assign victim = plru_victim(plru_q[set_q]);

    always_comb begin
        stage.valid  = valid_q;
        stage.inval  = inval_q;
        stage.set    = set_q;
        stage.tag    = tag_q;
        stage.victim = victim;
    end

endmodule

//--- design/l2_tag_dir.sv
`timescale 1ns/1ps

module l2_tag_dir (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req_valid,
    input  l2_tag_pkg::l2_req_t     req,
    output logic                    resp_valid,
    output l2_tag_pkg::l2_resp_t    resp
);

    l2_tag_pkg::l2_stage_t  stage;

    l2_tag_pkg::way_mask_t  match;
    l2_tag_pkg::way_mask_t  line_valid;
    l2_tag_pkg::tag_t       line_tags [l2_tag_pkg::NUM_WAYS];

    l2_tag_pkg::way_mask_t  wr_mask;
    logic                   wr_valid;
    logic                   touch;
    l2_tag_pkg::way_idx_t   touch_way;

    //////////////////////////////////////////////////
    // Request register and PLRU state
    //////////////////////////////////////////////////

    l2_req_front l2_req_front_inst (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .touch     (touch),
        .touch_way (touch_way),
        .stage     (stage)
    );

    //////////////////////////////////////////////////
    // Way banks
    //////////////////////////////////////////////////

    for (genvar w = 0; w < l2_tag_pkg::NUM_WAYS; w++) begin : g_way
        l2_way_bank l2_way_bank_inst (
            .clk        (clk),
            .rstn       (rstn),
            .stage      (stage),
            .wr_en      (wr_mask[w]),
            .wr_valid   (wr_valid),
            .match      (match[w]),
            .line_valid (line_valid[w]),
            .line_tag   (line_tags[w])
        );
    end

    //////////////////////////////////////////////////
    // Hit, allocation and response
    //////////////////////////////////////////////////

    l2_way_resolve l2_way_resolve_inst (
        .clk        (clk),
        .rstn       (rstn),
        .stage      (stage),
        .match      (match),
        .line_valid (line_valid),
        .line_tags  (line_tags),
        .wr_mask    (wr_mask),
        .wr_valid   (wr_valid),
        .touch      (touch),
        .touch_way  (touch_way),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

//--- design/l2_tag_pkg.sv
package l2_tag_pkg;

    //////////////////////////////////////////////////
    // Directory geometry
    //////////////////////////////////////////////////

    localparam int NUM_WAYS    = 8;
    localparam int WAY_BITS    = 3;
    localparam int SET_BITS    = 4;
    localparam int NUM_SETS    = 1 << SET_BITS;
    localparam int OFFSET_BITS = 6;
    localparam int ADDR_BITS   = 32;
    // Whatever sits above set and offset
    localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS;
    // One node per internal vertex of the 8-leaf tree
    localparam int PLRU_BITS   = NUM_WAYS - 1;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [SET_BITS-1:0]  set_idx_t;
    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [WAY_BITS-1:0]  way_idx_t;
    typedef logic [NUM_WAYS-1:0]  way_mask_t;

    // Bit 0 root, bits 1..2 half nodes, bits 3..6 leaf pairs
    // A node bit of 1 means its lower side was used more recently
    typedef logic [PLRU_BITS-1:0] plru_tree_t;

    //////////////////////////////////////////////////
    // Request, pipeline stage and response
    //////////////////////////////////////////////////

    typedef struct packed {
        logic  inval;
        addr_t addr;
    } l2_req_t;

    typedef struct packed {
        logic     valid;
        logic     inval;
        set_idx_t set;
        tag_t     tag;
        way_idx_t victim;   // PLRU pick for this set
    } l2_stage_t;

    typedef struct packed {
        logic     hit;
        way_idx_t way;
        logic     evicted;
        tag_t     evict_tag;  // zero unless evicted
    } l2_resp_t;

endpackage

//--- design/l2_way_bank.sv
`timescale 1ns/1ps

module l2_way_bank (
    input  logic                    clk,
    input  logic                    rstn,
    input  l2_tag_pkg::l2_stage_t   stage,
    input  logic                    wr_en,
    input  logic                    wr_valid,
    output logic                    match,
    output logic                    line_valid,
    output l2_tag_pkg::tag_t        line_tag
);

    //////////////////////////////////////////////////
    // Storage for one way
    //////////////////////////////////////////////////

    l2_tag_pkg::tag_t              tags_q [l2_tag_pkg::NUM_SETS];
    logic [l2_tag_pkg::NUM_SETS-1:0] valid_q;

    // Valid bits start clear
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[stage.set] <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags_q[stage.set] <= stage.tag;
        end
    end

    //////////////////////////////////////////////////
    // Lookup of the set in stage
    //////////////////////////////////////////////////

    assign line_valid = valid_q[stage.set];
    assign line_tag   = tags_q[stage.set];

    // Idle stage never matches
    assign match = stage.valid && line_valid && (line_tag == stage.tag);

endmodule

//--- design/l2_way_resolve.sv
`timescale 1ns/1ps

module l2_way_resolve (
    input  logic                    clk,
    input  logic                    rstn,
    input  l2_tag_pkg::l2_stage_t   stage,
    input  l2_tag_pkg::way_mask_t   match,
    input  l2_tag_pkg::way_mask_t   line_valid,
    input  l2_tag_pkg::tag_t        line_tags [l2_tag_pkg::NUM_WAYS],
    output l2_tag_pkg::way_mask_t   wr_mask,
    output logic                    wr_valid,
    output logic                    touch,
    output l2_tag_pkg::way_idx_t    touch_way,
    output logic                    resp_valid,
    output l2_tag_pkg::l2_resp_t    resp
);

    logic                   hit;
    logic                   has_free;
    l2_tag_pkg::way_idx_t   hit_way;
    l2_tag_pkg::way_idx_t   free_way;
    l2_tag_pkg::way_idx_t   alloc_way;
    l2_tag_pkg::l2_resp_t   resp_d;

    //////////////////////////////////////////////////
    // Way encoders
    //////////////////////////////////////////////////

    assign hit      = |match;
    assign has_free = ~&line_valid;

    // Downward scan leaves the lowest index
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = l2_tag_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = l2_tag_pkg::way_idx_t'(w);
            end
            if (!line_valid[w]) begin
                free_way = l2_tag_pkg::way_idx_t'(w);
            end
        end
    end

    // Empty ways win over the PLRU pick
    assign alloc_way = has_free ? free_way : stage.victim;

    //////////////////////////////////////////////////
    // Decision
    //////////////////////////////////////////////////

    always_comb begin
        wr_mask   = '0;
        wr_valid  = 1'b0;
        touch     = 1'b0;
        touch_way = alloc_way;
        resp_d    = '0;
        if (stage.valid) begin
            if (stage.inval) begin
                // Drop the matching line, leave PLRU alone
                if (hit) begin
                    wr_mask    = l2_tag_pkg::way_mask_t'(1) << hit_way;
                    resp_d.hit = 1'b1;
                    resp_d.way = hit_way;
                end
            end else if (hit) begin
                touch      = 1'b1;
                touch_way  = hit_way;
                resp_d.hit = 1'b1;
                resp_d.way = hit_way;
            end else begin
                // Fill, possibly displacing a live line
                wr_mask        = l2_tag_pkg::way_mask_t'(1) << alloc_way;
                wr_valid       = 1'b1;
                touch          = 1'b1;
                resp_d.way     = alloc_way;
                resp_d.evicted = line_valid[alloc_way];
                if (line_valid[alloc_way]) begin
                    resp_d.evict_tag = line_tags[alloc_way];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Response register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        resp <= resp_d;
    end

endmodule

//--- l2_tag_dir.f
design/l2_tag_pkg.sv
design/l2_req_front.sv
design/l2_way_bank.sv
design/l2_way_resolve.sv
design/l2_tag_dir.sv
sim/tb_clk_gen.sv
sim/l2_tag_dir_sva.sv
sim/tb_l2_tag_dir.sv

//--- sim/l2_tag_dir_sva.sv
`timescale 1ns/1ps

module l2_tag_dir_sva (
    input logic                    clk,
    input logic                    rstn,
    input logic                    req_valid,
    input l2_tag_pkg::l2_req_t     req,
    input logic                    resp_valid,
    input l2_tag_pkg::l2_resp_t    resp
);

    // One failure counter per assertion, summed for the testbench
    int n_latency    = 0;
    int n_echo       = 0;
    int n_hit_evict  = 0;
    int n_inval_evict = 0;
    int n_reset      = 0;
    int fail_count;

    assign fail_count = n_latency + n_echo + n_hit_evict + n_inval_evict + n_reset;

    //////////////////////////////////////////////////
    // Response timing
    //////////////////////////////////////////////////

    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> ##2 resp_valid)
    else begin
        $error("request produced no response two cycles later");
        n_latency++;
    end

    a_echo: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> $past(req_valid, 2))
    else begin
        $error("response without a request two cycles earlier");
        n_echo++;
    end

    // Synchronous reset clears the strobe one edge later
    a_reset: assert property (@(posedge clk) !rstn |=> !resp_valid)
    else begin
        $error("resp_valid high during reset");
        n_reset++;
    end

    //////////////////////////////////////////////////
    // Response fields
    //////////////////////////////////////////////////

    a_hit_evict: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> !(resp.hit && resp.evicted))
    else begin
        $error("hit and evicted both set");
        n_hit_evict++;
    end

    a_inval_evict: assert property (@(posedge clk) disable iff (!rstn)
        (resp_valid && $past(req.inval, 2)) |-> !resp.evicted)
    else begin
        $error("invalidate reported an eviction");
        n_inval_evict++;
    end

endmodule

bind l2_tag_dir l2_tag_dir_sva l2_tag_dir_sva_inst (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
);

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

//--- sim/tb_l2_tag_dir.sv
`timescale 1ns/1ps

module tb_l2_tag_dir;

    localparam int RAND_REQS     = 2000;
    localparam int DIRECTED_REQS = 26;
    localparam int CYCLE_LIMIT   = 3 * (RAND_REQS + DIRECTED_REQS) + 200;

    logic                   clk;
    logic                   rstn;
    logic                   req_valid;
    l2_tag_pkg::l2_req_t    req;
    logic                   resp_valid;
    l2_tag_pkg::l2_resp_t   resp;

    // Reference copy of the directory
    l2_tag_pkg::tag_t       m_tags  [l2_tag_pkg::NUM_SETS][l2_tag_pkg::NUM_WAYS];
    logic                   m_valid [l2_tag_pkg::NUM_SETS][l2_tag_pkg::NUM_WAYS];
    l2_tag_pkg::plru_tree_t m_plru  [l2_tag_pkg::NUM_SETS];

    l2_tag_pkg::l2_resp_t   exp_q [$];
    int                     err_cnt   = 0;
    int                     cycle_cnt = 0;
    logic [31:0]            rng_state;

    tb_clk_gen #(.PERIOD_NS(4)) tb_clk_gen_inst (.clk(clk));

    l2_tag_dir l2_tag_dir_inst (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    //////////////////////////////////////////////////
    // Random numbers and addresses
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic l2_tag_pkg::addr_t make_addr(
        input l2_tag_pkg::set_idx_t s,
        input l2_tag_pkg::tag_t t,
        input logic [l2_tag_pkg::OFFSET_BITS-1:0] off
    );
        return {t, s, off};
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Tree in heap order, node n has lower child 2n+1 and upper child 2n+2
    function automatic l2_tag_pkg::way_idx_t plru_pick(input l2_tag_pkg::plru_tree_t tree);
        int node;
        int way;
        node = 0;
        way  = 0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            way  = way * 2 + int'(tree[node]);
            node = 2 * node + 1 + int'(tree[node]);
        end
        return l2_tag_pkg::way_idx_t'(way);
    endfunction

    function automatic l2_tag_pkg::plru_tree_t plru_update(
        input l2_tag_pkg::plru_tree_t tree,
        input l2_tag_pkg::way_idx_t way
    );
        l2_tag_pkg::plru_tree_t t;
        int                     node;
        int                     dir;
        t    = tree;
        node = 0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            dir     = int'(way[lvl]);
            t[node] = (dir == 0);
            node    = 2 * node + 1 + dir;
        end
        return t;
    endfunction

    function automatic l2_tag_pkg::l2_resp_t ref_access(input l2_tag_pkg::l2_req_t r);
        l2_tag_pkg::set_idx_t s;
        l2_tag_pkg::tag_t     t;
        l2_tag_pkg::l2_resp_t rsp;
        int                   hit_w;
        int                   fill_w;
        s      = r.addr[l2_tag_pkg::OFFSET_BITS +: l2_tag_pkg::SET_BITS];
        t      = r.addr[l2_tag_pkg::ADDR_BITS-1 -: l2_tag_pkg::TAG_BITS];
        rsp    = '0;
        hit_w  = -1;
        fill_w = -1;
        for (int w = 0; w < l2_tag_pkg::NUM_WAYS; w++) begin
            if (hit_w < 0 && m_valid[s][w] && m_tags[s][w] == t) begin
                hit_w = w;
            end
            if (fill_w < 0 && !m_valid[s][w]) begin
                fill_w = w;
            end
        end
        if (hit_w >= 0) begin
            rsp.hit = 1'b1;
            rsp.way = l2_tag_pkg::way_idx_t'(hit_w);
            if (r.inval) begin
                m_valid[s][hit_w] = 1'b0;
            end else begin
                m_plru[s] = plru_update(m_plru[s], rsp.way);
            end
        end else if (!r.inval) begin
            // Empty way first, PLRU victim when the set is full
            if (fill_w < 0) begin
                fill_w = int'(plru_pick(m_plru[s]));
            end
            rsp.way = l2_tag_pkg::way_idx_t'(fill_w);
            if (m_valid[s][fill_w]) begin
                rsp.evicted   = 1'b1;
                rsp.evict_tag = m_tags[s][fill_w];
            end
            m_tags[s][fill_w]  = t;
            m_valid[s][fill_w] = 1'b1;
            m_plru[s]          = plru_update(m_plru[s], rsp.way);
        end
        return rsp;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and checking helpers
    //////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        end
    endtask

    // Called on a falling edge, returns one falling edge later
    task automatic send_req(input logic inval, input l2_tag_pkg::addr_t addr);
        l2_tag_pkg::l2_req_t r;
        r.inval   = inval;
        r.addr    = addr;
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(ref_access(r));
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        req_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Response comparison and timeout
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        l2_tag_pkg::l2_resp_t want;
        if (rstn && resp_valid) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Response at %0t ns arrived with no request outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                check_value(32'(resp.hit), 32'(want.hit), "hit");
                check_value(32'(resp.way), 32'(want.way), "way");
                check_value(32'(resp.evicted), 32'(want.evicted), "evicted");
                check_value(32'(resp.evict_tag), 32'(want.evict_tag), "evict_tag");
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with %0d responses still missing",
                     cycle_cnt, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0]          rnd;
        l2_tag_pkg::set_idx_t rs;
        l2_tag_pkg::tag_t     rt;
        int                   touch_order [6];
        rstn        = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rng_state   = 32'd9497;
        touch_order = '{6, 1, 3, 7, 0, 4};
        for (int s = 0; s < l2_tag_pkg::NUM_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < l2_tag_pkg::NUM_WAYS; w++) begin
                m_tags[s][w]  = '0;
                m_valid[s][w] = 1'b0;
            end
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        idle_cycles(2);

        // Cold fill of set 5, then hits on every way
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, make_addr(4'd5, l2_tag_pkg::tag_t'(32'h100 + i), 6'(i)));
        end
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, make_addr(4'd5, l2_tag_pkg::tag_t'(32'h100 + i), 6'd0));
        end
        idle_cycles(3);

        // Fixed touch order, then a ninth tag forces a PLRU eviction
        for (int i = 0; i < 6; i++) begin
            send_req(1'b0, make_addr(4'd5, l2_tag_pkg::tag_t'(32'h100 + touch_order[i]), 6'd0));
        end
        send_req(1'b0, make_addr(4'd5, 22'h1ff, 6'd0));
        idle_cycles(2);

        // Invalidate way 5, repeat it, then refill the hole
        send_req(1'b1, make_addr(4'd5, 22'h105, 6'd0));
        send_req(1'b1, make_addr(4'd5, 22'h105, 6'd0));
        send_req(1'b0, make_addr(4'd5, 22'h1a0, 6'd0));
        idle_cycles(3);

        // Random mix over sets 1, 5, 9 and 13
        for (int n = 0; n < RAND_REQS; n++) begin
            rnd = next_rand();
            rs  = {rnd[1:0], 2'b01};
            rt  = l2_tag_pkg::tag_t'(32'h200 + (32'(rnd[7:4]) % 32'd12));
            send_req(rnd[10:8] == 3'd0, make_addr(rs, rt, rnd[16:11]));
            if (rnd[13:12] == 2'd0) begin
                idle_cycles(1 + int'(rnd[15:14]));
            end
        end

        // Drain the pipeline
        for (int i = 0; i < 16 && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        idle_cycles(4);
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        err_cnt += l2_tag_dir_inst.l2_tag_dir_sva_inst.fail_count;

        $display("Done: %0d errors, %0d assertion failures",
                 err_cnt, l2_tag_dir_inst.l2_tag_dir_sva_inst.fail_count);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
